// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // 10 ns period
    end

    initial begin
        rstn_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rstn_o = 1'b1;            // released with the other inputs
    end

endmodule

`default_nettype wire

// File: bench/tb_debug_dtm.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_params.svh"

module tb_debug_dtm;

    localparam logic [3:0]  ID_VERSION = 4'h3;
    localparam logic [15:0] ID_PARTID  = 16'h1234;
    localparam logic [10:0] ID_MANID   = 11'h05A;
    localparam int          WAIT_LIMIT = 400;   // clk cycles per DMI access

    logic                   clk;
    logic                   rstn;
    logic                   jtag_trst;
    logic                   jtag_tck;
    logic                   jtag_tdi;
    logic                   jtag_tms;
    logic                   jtag_tdo;
    logic                   req_valid;
    logic                   req_ready;
    logic [`DTM_ABITS-1:0]  req_addr;
    logic [`DTM_DATA_W-1:0] req_data;
    logic [`DTM_OP_W-1:0]   req_op;
    logic                   rsp_valid;
    logic                   rsp_ready;
    logic [`DTM_DATA_W-1:0] rsp_data;
    logic [`DTM_OP_W-1:0]   rsp_op;

    // DMI responder model
    logic [`DTM_DATA_W-1:0] dm_mem [0:(1 << `DTM_ABITS)-1];
    logic                   hold_ready = 1'b0;
    logic [`DTM_OP_W-1:0]   force_op   = '0;   // response op returned by the model
    logic [`DTM_ABITS-1:0]  seen_addr;
    logic [`DTM_DATA_W-1:0] seen_data;
    logic [`DTM_OP_W-1:0]   seen_op;
    int                     req_count  = 0;
    int                     rsp_count  = 0;

    logic [15:0]            stim_lfsr;
    logic [15:0]            model_lfsr;
    int                     check_count    = 0;
    int                     value_errors   = 0;
    int                     timeout_errors = 0;

    tb_clock u_clk (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    debug_dtm #(
        .IDCODE_VERSION (ID_VERSION),
        .IDCODE_PARTID  (ID_PARTID),
        .IDCODE_MANID   (ID_MANID)
    ) u_dut (
        .clk_i             (clk),
        .rstn_i            (rstn),
        .jtag_trst_i       (jtag_trst),
        .jtag_tck_i        (jtag_tck),
        .jtag_tdi_i        (jtag_tdi),
        .jtag_tms_i        (jtag_tms),
        .jtag_tdo_o        (jtag_tdo),
        .dmi_req_valid_o   (req_valid),
        .dmi_req_ready_i   (req_ready),
        .dmi_req_address_o (req_addr),
        .dmi_req_data_o    (req_data),
        .dmi_req_op_o      (req_op),
        .dmi_rsp_valid_i   (rsp_valid),
        .dmi_rsp_ready_o   (rsp_ready),
        .dmi_rsp_data_i    (rsp_data),
        .dmi_rsp_op_i      (rsp_op)
    );

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int n, output logic [39:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            val   = {val[38:0], state[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [5:0] a);
        return 32'h9E3779B9 * ({26'd0, a} + 32'd1);
    endfunction

    function automatic logic [63:0] dmi_word(input logic [5:0] a, input logic [31:0] d,
                                             input logic [1:0] op);
        return {24'd0, a, d, op};   // op in the LSBs
    endfunction

    function automatic logic [63:0] dtmcs_word(input logic [1:0] status);
        return {49'd0, 3'd0, status, 6'd6, 4'd1};   // idle 0, dmistat, abits 6, version 1
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR: %s expected 0x%0h got 0x%0h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one TCK period with TDO taken just before the rising edge
    task automatic jtag_cycle(input logic tms, input logic tdi, output logic tdo);
        jtag_tck = 1'b0;
        jtag_tms = tms;
        jtag_tdi = tdi;
        repeat (4) step();
        tdo      = jtag_tdo;
        jtag_tck = 1'b1;
        repeat (4) step();
    endtask

    task automatic ir_scan(input logic [`DTM_IR_W-1:0] ir);
        logic [63:0] cap;
        logic        tdo_bit;
        cap = '0;
        jtag_cycle(1'b1, 1'b0, tdo_bit);   // select DR
        jtag_cycle(1'b1, 1'b0, tdo_bit);   // select IR
        jtag_cycle(1'b0, 1'b0, tdo_bit);   // capture
        jtag_cycle(1'b0, 1'b0, tdo_bit);
        for (int i = 0; i < `DTM_IR_W; i++) begin
            jtag_cycle(i == `DTM_IR_W - 1, ir[i], tdo_bit);
            cap[i] = tdo_bit;
        end
        jtag_cycle(1'b1, 1'b0, tdo_bit);   // update
        jtag_cycle(1'b0, 1'b0, tdo_bit);   // run-test/idle
        check_value("ir capture", 64'h1, cap);
    endtask

    task automatic dr_scan(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic tdo_bit;
        dout = '0;
        jtag_cycle(1'b1, 1'b0, tdo_bit);   // select DR
        jtag_cycle(1'b0, 1'b0, tdo_bit);   // capture
        jtag_cycle(1'b0, 1'b0, tdo_bit);
        for (int i = 0; i < len; i++) begin
            jtag_cycle(i == len - 1, din[i], tdo_bit);
            dout[i] = tdo_bit;
        end
        jtag_cycle(1'b1, 1'b0, tdo_bit);   // update
        jtag_cycle(1'b0, 1'b0, tdo_bit);
    endtask

    task automatic wait_response(input int prev);
        int guard;
        guard = 0;
        while (rsp_count == prev && guard < WAIT_LIMIT) begin
            step();
            guard++;
        end
        assert (rsp_count != prev) else begin
            $display("timeout: DMI access did not complete within %0d cycles", WAIT_LIMIT);
            timeout_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // DMI responder stepping once per clk
    // ----------------------------------------------------------------------
    initial begin : dmi_responder
        logic [39:0] rnd;
        int          state;   // 0 wait request, 1 response delay, 2 response given
        int          delay;
        model_lfsr = 16'd97;
        req_ready  = 1'b0;
        rsp_valid  = 1'b0;
        rsp_data   = '0;
        rsp_op     = '0;
        state      = 0;
        delay      = 0;
        for (int i = 0; i < (1 << `DTM_ABITS); i++) begin
            dm_mem[i] = fill_word(i[5:0]);
        end
        forever begin
            step();
            if (rstn === 1'b1) begin
                case (state)
                    0: begin
                        check_value("dmi_rsp_ready_o", 64'h0, rsp_ready);
                        if (req_valid) begin
                            seen_addr = req_addr;
                            seen_data = req_data;
                            seen_op   = req_op;
                            req_count++;
                            if (req_op == `DTM_OP_WRITE) dm_mem[req_addr] = req_data;
                            req_ready = 1'b0;
                            draw_bits(model_lfsr, 2, rnd);
                            delay = rnd[1:0];
                            state = 1;
                        end else if (hold_ready) begin
                            req_ready = 1'b0;
                        end else if (delay > 0) begin
                            delay--;
                        end else begin
                            req_ready = 1'b1;
                        end
                    end
                    1: begin
                        check_value("dmi_req_valid_o", 64'h0, req_valid);   // single pulse
                        check_value("dmi_rsp_ready_o", 64'h1, rsp_ready);
                        if (delay > 0) begin
                            delay--;
                        end else begin
                            rsp_valid = 1'b1;
                            rsp_data  = (seen_op == `DTM_OP_READ) ? dm_mem[seen_addr] : '0;
                            rsp_op    = force_op;
                            state     = 2;
                        end
                    end
                    default: begin
                        check_value("dmi_rsp_ready_o", 64'h0, rsp_ready);
                        rsp_valid = 1'b0;
                        rsp_data  = '0;
                        rsp_op    = '0;   // op only counts while a response is given
                        rsp_count++;
                        draw_bits(model_lfsr, 2, rnd);
                        delay = rnd[1:0];
                        state = 0;
                    end
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin : stimulus
        logic [63:0] dout;
        logic [63:0] pattern;
        logic [39:0] rnd;
        logic [5:0]  addr_a;
        logic [5:0]  addr_b;
        logic [31:0] data_a;
        logic [31:0] data_c;
        int          prev;
        int          prev_req;
        int          guard;
        logic        tdo_bit;

        jtag_trst = 1'b1;
        jtag_tck  = 1'b0;
        jtag_tdi  = 1'b0;
        jtag_tms  = 1'b1;
        stim_lfsr = 16'd97;

        guard = 0;
        while (rstn !== 1'b1 && guard < 20) begin
            step();
            guard++;
        end
        assert (rstn === 1'b1) else begin
            $display("timeout: reset was never released");
            timeout_errors++;
        end
        step();
        check_value("jtag_tdo_o", 64'h0, jtag_tdo);
        check_value("dmi_req_valid_o", 64'h0, req_valid);
        check_value("dmi_rsp_ready_o", 64'h0, rsp_ready);

        // IDCODE right after a TRST pulse
        jtag_trst = 1'b0;
        repeat (4) step();
        jtag_trst = 1'b1;
        repeat (4) step();
        jtag_cycle(1'b0, 1'b0, tdo_bit);   // to run-test/idle
        dr_scan(32, 64'd0, dout);
        check_value("idcode", {32'd0, ID_VERSION, ID_PARTID, ID_MANID, 1'b1}, dout);

        // bypass delays by one bit
        ir_scan(5'h1F);
        draw_bits(stim_lfsr, 16, rnd);
        pattern = {48'd0, rnd[15:0]};
        dr_scan(16, pattern, dout);
        check_value("bypass", (pattern << 1) & 64'hFFFF, dout);

        ir_scan(`DTM_IR_DTMCS);
        dr_scan(32, 64'd0, dout);
        check_value("dtmcs", dtmcs_word(2'd0), dout);

        // ------------------------------------------------------------------
        // DMI write then read back
        // ------------------------------------------------------------------
        ir_scan(`DTM_IR_DMI);
        draw_bits(stim_lfsr, 6, rnd);
        addr_a = rnd[5:0];
        draw_bits(stim_lfsr, 32, rnd);
        data_a   = rnd[31:0];
        prev     = rsp_count;
        prev_req = req_count;
        dr_scan(40, dmi_word(addr_a, data_a, `DTM_OP_WRITE), dout);
        wait_response(prev);
        check_value("request count", prev_req + 1, req_count);
        check_value("dmi_req_address_o", addr_a, seen_addr);
        check_value("dmi_req_data_o", data_a, seen_data);
        check_value("dmi_req_op_o", `DTM_OP_WRITE, seen_op);

        prev = rsp_count;
        dr_scan(40, dmi_word(addr_a, 32'd0, `DTM_OP_READ), dout);
        check_value("dmi status", 64'h0, dout[1:0]);
        wait_response(prev);
        dr_scan(40, 64'd0, dout);
        check_value("dmi address", addr_a, dout[39:34]);
        check_value("dmi data", data_a, dout[33:2]);
        check_value("dmi status", 64'h0, dout[1:0]);

        // busy while ready is held low
        hold_ready = 1'b1;
        addr_b     = addr_a ^ 6'h20;
        prev       = rsp_count;
        dr_scan(40, dmi_word(addr_b, 32'd0, `DTM_OP_READ), dout);
        dr_scan(40, 64'd0, dout);
        check_value("dmi status", `DTM_OP_BUSY, dout[1:0]);
        check_value("response count while held", prev, rsp_count);
        hold_ready = 1'b0;
        wait_response(prev);
        dr_scan(40, 64'd0, dout);
        check_value("dmi status", `DTM_OP_BUSY, dout[1:0]);   // sticky
        check_value("dmi address", addr_b, dout[39:34]);
        check_value("dmi data", fill_word(addr_b), dout[33:2]);
        ir_scan(`DTM_IR_DTMCS);
        dr_scan(32, 64'h1_0000, dout);   // dmireset
        check_value("dtmcs", dtmcs_word(`DTM_OP_BUSY), dout);
        ir_scan(`DTM_IR_DMI);
        dr_scan(40, 64'd0, dout);
        check_value("dmi status", 64'h0, dout[1:0]);

        // ------------------------------------------------------------------
        // error response stays until dmireset
        // ------------------------------------------------------------------
        force_op = 2'd2;
        draw_bits(stim_lfsr, 32, rnd);
        data_c = rnd[31:0];
        prev   = rsp_count;
        dr_scan(40, dmi_word(addr_a, data_c, `DTM_OP_WRITE), dout);
        wait_response(prev);
        force_op = 2'd0;
        dr_scan(40, 64'd0, dout);
        check_value("dmi status", 64'h2, dout[1:0]);
        prev = rsp_count;
        dr_scan(40, dmi_word(addr_a, 32'd0, `DTM_OP_READ), dout);
        wait_response(prev);
        dr_scan(40, 64'd0, dout);
        check_value("dmi status", 64'h2, dout[1:0]);
        check_value("dmi data", data_c, dout[33:2]);
        ir_scan(`DTM_IR_DTMCS);
        dr_scan(32, 64'h1_0000, dout);
        check_value("dtmcs", dtmcs_word(2'd2), dout);
        ir_scan(`DTM_IR_DMI);
        dr_scan(40, 64'd0, dout);
        check_value("dmi status", 64'h0, dout[1:0]);

        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 check_count, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/dtm_pkg.sv
verilog/dtm_dmi_if.sv
verilog/jtag_sync.sv
verilog/jtag_tap.sv
verilog/dmi_ctrl.sv
verilog/debug_dtm.sv
bench/tb_clock.sv
bench/tb_debug_dtm.sv

// File: verilog/debug_dtm.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_params.svh"

module debug_dtm #(
    parameter logic [3:0]  IDCODE_VERSION = 4'h0,
    parameter logic [15:0] IDCODE_PARTID  = 16'h0000,
    parameter logic [10:0] IDCODE_MANID   = 11'h000
) (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    // JTAG
    input  wire                    jtag_trst_i,
    input  wire                    jtag_tck_i,
    input  wire                    jtag_tdi_i,
    input  wire                    jtag_tms_i,
    output logic                   jtag_tdo_o,
    // debug module interface
    output logic                   dmi_req_valid_o,
    input  wire                    dmi_req_ready_i,
    output logic [`DTM_ABITS-1:0]  dmi_req_address_o,
    output logic [`DTM_DATA_W-1:0] dmi_req_data_o,
    output logic [`DTM_OP_W-1:0]   dmi_req_op_o,
    input  wire                    dmi_rsp_valid_i,
    output logic                   dmi_rsp_ready_o,
    input  wire [`DTM_DATA_W-1:0]  dmi_rsp_data_i,
    input  wire [`DTM_OP_W-1:0]    dmi_rsp_op_i
);

    logic tck_rise;
    logic tck_fall;
    logic tdi;
    logic tms;
    logic trst_n;

    jtag_sync u_sync (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .jtag_trst_i (jtag_trst_i),
        .jtag_tck_i  (jtag_tck_i),
        .jtag_tdi_i  (jtag_tdi_i),
        .jtag_tms_i  (jtag_tms_i),
        .tck_rise_o  (tck_rise),
        .tck_fall_o  (tck_fall),
        .tdi_o       (tdi),
        .tms_o       (tms),
        .trst_n_o    (trst_n)
    );

    dtm_dmi_if u_if ();

    jtag_tap #(
        .IDCODE_VERSION (IDCODE_VERSION),
        .IDCODE_PARTID  (IDCODE_PARTID),
        .IDCODE_MANID   (IDCODE_MANID)
    ) u_tap (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .tck_rise_i (tck_rise),
        .tck_fall_i (tck_fall),
        .tdi_i      (tdi),
        .tms_i      (tms),
        .trst_n_i   (trst_n),
        .jtag_tdo_o (jtag_tdo_o),
        .dmi_if     (u_if)
    );

    dmi_ctrl u_dmi (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .dmi_req_ready_i   (dmi_req_ready_i),
        .dmi_rsp_valid_i   (dmi_rsp_valid_i),
        .dmi_rsp_data_i    (dmi_rsp_data_i),
        .dmi_rsp_op_i      (dmi_rsp_op_i),
        .dmi_req_valid_o   (dmi_req_valid_o),
        .dmi_req_address_o (dmi_req_address_o),
        .dmi_req_data_o    (dmi_req_data_o),
        .dmi_req_op_o      (dmi_req_op_o),
        .dmi_rsp_ready_o   (dmi_rsp_ready_o),
        .dmi_if            (u_if)
    );

endmodule

`default_nettype wire

// File: verilog/dmi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_params.svh"

module dmi_ctrl (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  wire                    dmi_req_ready_i,
    input  wire                    dmi_rsp_valid_i,
    input  wire [`DTM_DATA_W-1:0]  dmi_rsp_data_i,
    input  wire [`DTM_OP_W-1:0]    dmi_rsp_op_i,
    output logic                   dmi_req_valid_o,
    output logic [`DTM_ABITS-1:0]  dmi_req_address_o,
    output logic [`DTM_DATA_W-1:0] dmi_req_data_o,
    output logic [`DTM_OP_W-1:0]   dmi_req_op_o,
    output logic                   dmi_rsp_ready_o,
    dtm_dmi_if.ctrl                dmi_if
);

    dtm_pkg::dmi_state_e state_q;

    logic [`DTM_ABITS-1:0]  addr_q;
    logic [`DTM_DATA_W-1:0] wdata_q;
    logic [`DTM_DATA_W-1:0] rdata_q;
    logic [`DTM_OP_W-1:0]   op_q;
    logic [`DTM_OP_W-1:0]   status_q;   // sticky response status
    logic                   rsp_ready;

    // --------------------------------------------------------------------
    // request sequencer
    // --------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= dtm_pkg::DMI_IDLE;
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
            op_q    <= '0;
        end else begin
            case (state_q)
                dtm_pkg::DMI_IDLE: begin
                    if (dmi_if.dmi_update && (dmi_if.req_op == `DTM_OP_READ ||
                                              dmi_if.req_op == `DTM_OP_WRITE)) begin
                        addr_q  <= dmi_if.req_addr;
                        wdata_q <= dmi_if.req_wdata;
                        op_q    <= dmi_if.req_op;
                        state_q <= (dmi_if.req_op == `DTM_OP_READ) ? dtm_pkg::DMI_READ_WAIT
                                                                   : dtm_pkg::DMI_WRITE_WAIT;
                    end
                end
                dtm_pkg::DMI_READ_WAIT: begin
                    if (dmi_req_ready_i) state_q <= dtm_pkg::DMI_READ;
                end
                dtm_pkg::DMI_READ: state_q <= dtm_pkg::DMI_READ_BUSY;   // request issued
                dtm_pkg::DMI_READ_BUSY: begin
                    if (dmi_rsp_valid_i) begin
                        rdata_q <= dmi_rsp_data_i;
                        state_q <= dtm_pkg::DMI_IDLE;
                    end
                end
                dtm_pkg::DMI_WRITE_WAIT: begin
                    if (dmi_req_ready_i) state_q <= dtm_pkg::DMI_WRITE;
                end
                dtm_pkg::DMI_WRITE: state_q <= dtm_pkg::DMI_WRITE_BUSY;
                dtm_pkg::DMI_WRITE_BUSY: begin
                    if (dmi_rsp_valid_i) state_q <= dtm_pkg::DMI_IDLE;
                end
                default: state_q <= dtm_pkg::DMI_IDLE;
            endcase
        end
    end

    assign rsp_ready = (state_q == dtm_pkg::DMI_READ_BUSY) ||
                       (state_q == dtm_pkg::DMI_WRITE_BUSY);

    // --------------------------------------------------------------------
    // sticky status
    // --------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            status_q <= '0;
        end else if (dmi_if.dtmcs_update && dmi_if.dmireset) begin
            status_q <= '0;
        end else if (dmi_if.dmi_update && state_q != dtm_pkg::DMI_IDLE) begin
            status_q <= `DTM_OP_BUSY;   // scan overran a pending access
        end else if (rsp_ready) begin
            status_q <= status_q | dmi_rsp_op_i;
        end
    end

    // outputs
    assign dmi_req_valid_o   = (state_q == dtm_pkg::DMI_READ) ||
                               (state_q == dtm_pkg::DMI_WRITE);
    assign dmi_rsp_ready_o   = rsp_ready;
    assign dmi_req_address_o = addr_q;
    assign dmi_req_data_o    = wdata_q;
    assign dmi_req_op_o      = op_q;

    // capture path back to the TAP
    assign dmi_if.cap_addr   = addr_q;
    assign dmi_if.cap_rdata  = rdata_q;
    assign dmi_if.cap_status = (state_q != dtm_pkg::DMI_IDLE) ? `DTM_OP_BUSY : status_q;

endmodule

`default_nettype wire

// File: verilog/dtm_dmi_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_params.svh"

interface dtm_dmi_if;

    // TAP to controller
    logic                    dmi_update;    // DR update with DMI selected
    logic                    dtmcs_update;  // DR update with DTMCS selected
    logic                    dmireset;      // dtmcs bit 16
    logic [`DTM_ABITS-1:0]   req_addr;
    logic [`DTM_DATA_W-1:0]  req_wdata;
    logic [`DTM_OP_W-1:0]    req_op;

    // controller to TAP, loaded in DR_CAPTURE
    logic [`DTM_ABITS-1:0]   cap_addr;
    logic [`DTM_DATA_W-1:0]  cap_rdata;
    logic [`DTM_OP_W-1:0]    cap_status;

    modport tap (
        output dmi_update, dtmcs_update, dmireset, req_addr, req_wdata, req_op,
        input  cap_addr, cap_rdata, cap_status
    );

    modport ctrl (
        input  dmi_update, dtmcs_update, dmireset, req_addr, req_wdata, req_op,
        output cap_addr, cap_rdata, cap_status
    );

endinterface

`default_nettype wire

// File: verilog/dtm_params.svh
`ifndef DTM_PARAMS_SVH
`define DTM_PARAMS_SVH

// instruction register
`define DTM_IR_W       5
`define DTM_IR_IDCODE  5'b00001
`define DTM_IR_DTMCS   5'b10000
`define DTM_IR_DMI     5'b10001

// DMI word layout, address on top and op in the LSBs
`define DTM_ABITS      6
`define DTM_DATA_W     32
`define DTM_OP_W       2
`define DTM_DMI_W      (`DTM_ABITS + `DTM_DATA_W + `DTM_OP_W)

// fixed dtmcs fields
`define DTM_VERSION    4'd1    // debug spec 0.13 / 1.0
`define DTM_IDLE       3'd0    // no run-test-idle cycles needed

// op codes on request, status codes on capture
`define DTM_OP_READ    2'b01
`define DTM_OP_WRITE   2'b10
`define DTM_OP_BUSY    2'b11

`endif

// File: verilog/dtm_pkg.sv
`default_nettype none

package dtm_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        LOGIC_RESET,
        RUN_IDLE,
        DR_SCAN,
        DR_CAPTURE,
        DR_SHIFT,
        DR_EXIT1,
        DR_PAUSE,
        DR_EXIT2,
        DR_UPDATE,
        IR_SCAN,
        IR_CAPTURE,
        IR_SHIFT,
        IR_EXIT1,
        IR_PAUSE,
        IR_EXIT2,
        IR_UPDATE
    } tap_state_e;

    // DMI access sequencer
    typedef enum logic [2:0] {
        DMI_IDLE,
        DMI_READ_WAIT,    // request queued, DM not ready yet
        DMI_READ,         // req_valid pulse
        DMI_READ_BUSY,    // waiting for response
        DMI_WRITE_WAIT,
        DMI_WRITE,
        DMI_WRITE_BUSY
    } dmi_state_e;

endpackage

`default_nettype wire

// File: verilog/jtag_sync.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_sync (
    input  wire  clk_i,
    input  wire  rstn_i,
    input  wire  jtag_trst_i,
    input  wire  jtag_tck_i,
    input  wire  jtag_tdi_i,
    input  wire  jtag_tms_i,
    output logic tck_rise_o,
    output logic tck_fall_o,
    output logic tdi_o,
    output logic tms_o,
    output logic trst_n_o
);

    logic [2:0] trst_q;   // [0] is the newest sample
    logic [2:0] tck_q;
    logic [2:0] tdi_q;
    logic [2:0] tms_q;

    // --------------------------------------------------------------------
    // pin synchronizers
    // --------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            trst_q <= '0;   // hold the TAP in reset until TRST is seen high
            tck_q  <= '0;
            tdi_q  <= '0;
            tms_q  <= '0;
        end else begin
            trst_q <= {trst_q[1:0], jtag_trst_i};
            tck_q  <= {tck_q[1:0], jtag_tck_i};
            tdi_q  <= {tdi_q[1:0], jtag_tdi_i};
            tms_q  <= {tms_q[1:0], jtag_tms_i};
        end
    end

    // --------------------------------------------------------------------
    // edge detect on the two oldest stages
    // --------------------------------------------------------------------
    assign tck_rise_o = (tck_q[2:1] == 2'b01);
    assign tck_fall_o = (tck_q[2:1] == 2'b10);

    // a single-cycle glitch on TRST does not reset the TAP
    assign trst_n_o = (trst_q[2:1] != 2'b00);

    assign tdi_o = tdi_q[2];
    assign tms_o = tms_q[2];

endmodule

`default_nettype wire

// File: verilog/jtag_tap.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_params.svh"

module jtag_tap #(
    parameter logic [3:0]  IDCODE_VERSION = 4'h0,
    parameter logic [15:0] IDCODE_PARTID  = 16'h0000,
    parameter logic [10:0] IDCODE_MANID   = 11'h000
) (
    input  wire        clk_i,
    input  wire        rstn_i,
    input  wire        tck_rise_i,
    input  wire        tck_fall_i,
    input  wire        tdi_i,
    input  wire        tms_i,
    input  wire        trst_n_i,
    output logic       jtag_tdo_o,
    dtm_dmi_if.tap     dmi_if
);

    dtm_pkg::tap_state_e state_q;
    dtm_pkg::tap_state_e state_d;

    logic [`DTM_IR_W-1:0]  ir_q;
    logic [31:0]           idcode_q;
    logic [31:0]           dtmcs_q;
    logic [`DTM_DMI_W-1:0] dmi_q;
    logic                  bypass_q;

    logic [31:0]           dtmcs_cap;
    logic [`DTM_DMI_W-1:0] dmi_cap;
    logic                  in_update_q;
    logic                  update_entry;
    logic                  dmi_update_q;
    logic                  dtmcs_update_q;

    // --------------------------------------------------------------------
    // TAP state machine
    // --------------------------------------------------------------------
    always_comb begin
        case (state_q)
            dtm_pkg::LOGIC_RESET: state_d = tms_i ? dtm_pkg::LOGIC_RESET : dtm_pkg::RUN_IDLE;
            dtm_pkg::RUN_IDLE:    state_d = tms_i ? dtm_pkg::DR_SCAN     : dtm_pkg::RUN_IDLE;
            dtm_pkg::DR_SCAN:     state_d = tms_i ? dtm_pkg::IR_SCAN     : dtm_pkg::DR_CAPTURE;
            dtm_pkg::DR_CAPTURE:  state_d = tms_i ? dtm_pkg::DR_EXIT1    : dtm_pkg::DR_SHIFT;
            dtm_pkg::DR_SHIFT:    state_d = tms_i ? dtm_pkg::DR_EXIT1    : dtm_pkg::DR_SHIFT;
            dtm_pkg::DR_EXIT1:    state_d = tms_i ? dtm_pkg::DR_UPDATE   : dtm_pkg::DR_PAUSE;
            dtm_pkg::DR_PAUSE:    state_d = tms_i ? dtm_pkg::DR_EXIT2    : dtm_pkg::DR_PAUSE;
            dtm_pkg::DR_EXIT2:    state_d = tms_i ? dtm_pkg::DR_UPDATE   : dtm_pkg::DR_SHIFT;
            dtm_pkg::DR_UPDATE:   state_d = tms_i ? dtm_pkg::DR_SCAN     : dtm_pkg::RUN_IDLE;
            dtm_pkg::IR_SCAN:     state_d = tms_i ? dtm_pkg::LOGIC_RESET : dtm_pkg::IR_CAPTURE;
            dtm_pkg::IR_CAPTURE:  state_d = tms_i ? dtm_pkg::IR_EXIT1    : dtm_pkg::IR_SHIFT;
            dtm_pkg::IR_SHIFT:    state_d = tms_i ? dtm_pkg::IR_EXIT1    : dtm_pkg::IR_SHIFT;
            dtm_pkg::IR_EXIT1:    state_d = tms_i ? dtm_pkg::IR_UPDATE   : dtm_pkg::IR_PAUSE;
            dtm_pkg::IR_PAUSE:    state_d = tms_i ? dtm_pkg::IR_EXIT2    : dtm_pkg::IR_PAUSE;
            dtm_pkg::IR_EXIT2:    state_d = tms_i ? dtm_pkg::IR_UPDATE   : dtm_pkg::IR_SHIFT;
            dtm_pkg::IR_UPDATE:   state_d = tms_i ? dtm_pkg::DR_SCAN     : dtm_pkg::RUN_IDLE;
            default:              state_d = dtm_pkg::LOGIC_RESET;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= dtm_pkg::LOGIC_RESET;
        end else if (!trst_n_i) begin
            state_q <= dtm_pkg::LOGIC_RESET;
        end else if (tck_rise_i) begin
            state_q <= state_d;   // TMS sampled on rising TCK
        end
    end

    // --------------------------------------------------------------------
    // instruction register
    // --------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ir_q <= `DTM_IR_IDCODE;
        end else if (state_q == dtm_pkg::LOGIC_RESET || state_q == dtm_pkg::IR_CAPTURE) begin
            ir_q <= `DTM_IR_IDCODE;
        end else if (state_q == dtm_pkg::IR_SHIFT && tck_rise_i) begin
            ir_q <= {tdi_i, ir_q[`DTM_IR_W-1:1]};   // lsb first
        end
    end

    // capture values
    assign dtmcs_cap = {17'd0, `DTM_IDLE, dmi_if.cap_status,
                        6'(`DTM_ABITS), `DTM_VERSION};
    assign dmi_cap   = {dmi_if.cap_addr, dmi_if.cap_rdata, dmi_if.cap_status};

    // --------------------------------------------------------------------
    // data registers and TDO
    // --------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            idcode_q   <= '0;
            dtmcs_q    <= '0;
            dmi_q      <= '0;
            bypass_q   <= 1'b0;
            jtag_tdo_o <= 1'b0;
        end else begin
            if (state_q == dtm_pkg::DR_CAPTURE) begin
                case (ir_q)
                    `DTM_IR_IDCODE: idcode_q <= {IDCODE_VERSION, IDCODE_PARTID,
                                                 IDCODE_MANID, 1'b1};
                    `DTM_IR_DTMCS:  dtmcs_q  <= dtmcs_cap;
                    `DTM_IR_DMI:    dmi_q    <= dmi_cap;
                    default:        bypass_q <= 1'b0;
                endcase
            end else if (state_q == dtm_pkg::DR_SHIFT && tck_rise_i) begin
                case (ir_q)
                    `DTM_IR_IDCODE: idcode_q <= {tdi_i, idcode_q[31:1]};
                    `DTM_IR_DTMCS:  dtmcs_q  <= {tdi_i, dtmcs_q[31:1]};
                    `DTM_IR_DMI:    dmi_q    <= {tdi_i, dmi_q[`DTM_DMI_W-1:1]};
                    default:        bypass_q <= tdi_i;
                endcase
            end

            if (tck_fall_i) begin   // TDO changes on falling TCK
                if (state_q == dtm_pkg::IR_SHIFT) begin
                    jtag_tdo_o <= ir_q[0];
                end else begin
                    case (ir_q)
                        `DTM_IR_IDCODE: jtag_tdo_o <= idcode_q[0];
                        `DTM_IR_DTMCS:  jtag_tdo_o <= dtmcs_q[0];
                        `DTM_IR_DMI:    jtag_tdo_o <= dmi_q[0];
                        default:        jtag_tdo_o <= bypass_q;
                    endcase
                end
            end
        end
    end

    // --------------------------------------------------------------------
    // update strobes
    // --------------------------------------------------------------------
    assign update_entry = (state_q == dtm_pkg::DR_UPDATE) && !in_update_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            in_update_q    <= 1'b0;
            dmi_update_q   <= 1'b0;
            dtmcs_update_q <= 1'b0;
        end else begin
            in_update_q    <= (state_q == dtm_pkg::DR_UPDATE);
            dmi_update_q   <= update_entry && (ir_q == `DTM_IR_DMI);
            dtmcs_update_q <= update_entry && (ir_q == `DTM_IR_DTMCS);
        end
    end

    assign dmi_if.dmi_update   = dmi_update_q;
    assign dmi_if.dtmcs_update = dtmcs_update_q;
    assign dmi_if.dmireset     = dtmcs_q[16];
    assign dmi_if.req_op       = dmi_q[`DTM_OP_W-1:0];
    assign dmi_if.req_wdata    = dmi_q[`DTM_OP_W +: `DTM_DATA_W];
    assign dmi_if.req_addr     = dmi_q[`DTM_OP_W + `DTM_DATA_W +: `DTM_ABITS];

endmodule

`default_nettype wire
